// ==== logic/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;  // product, or {remainder, quotient}
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;

    // primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_SLTIU = 6'h0b;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;

    // r-type funct field
    localparam funct_t FN_SLL   = 6'h00;
    localparam funct_t FN_SRL   = 6'h02;
    localparam funct_t FN_SRA   = 6'h03;
    localparam funct_t FN_SLLV  = 6'h04;
    localparam funct_t FN_SRLV  = 6'h06;
    localparam funct_t FN_SRAV  = 6'h07;
    localparam funct_t FN_MFHI  = 6'h10;
    localparam funct_t FN_MTHI  = 6'h11;
    localparam funct_t FN_MFLO  = 6'h12;
    localparam funct_t FN_MTLO  = 6'h13;
    localparam funct_t FN_MULT  = 6'h18;
    localparam funct_t FN_MULTU = 6'h19;
    localparam funct_t FN_DIV   = 6'h1a;
    localparam funct_t FN_DIVU  = 6'h1b;
    localparam funct_t FN_ADD   = 6'h20;
    localparam funct_t FN_ADDU  = 6'h21;
    localparam funct_t FN_SUB   = 6'h22;
    localparam funct_t FN_SUBU  = 6'h23;
    localparam funct_t FN_AND   = 6'h24;
    localparam funct_t FN_OR    = 6'h25;
    localparam funct_t FN_XOR   = 6'h26;
    localparam funct_t FN_NOR   = 6'h27;
    localparam funct_t FN_SLT   = 6'h2a;
    localparam funct_t FN_SLTU  = 6'h2b;

endpackage

`default_nettype wire

// ==== logic/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    typedef enum logic [4:0] {
        ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_PASS_A,
        ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
        ALU_NONE
    } alu_op_t;

    typedef enum logic [1:0] {WB_ALU, WB_HI, WB_LO, WB_NONE} wb_sel_t;

    // how HI/LO get written
    typedef enum logic [2:0] {
        HILO_NONE, HILO_PRODUCT, HILO_DIVIDE, HILO_HI, HILO_LO
    } hilo_wr_t;

    typedef struct packed {
        alu_op_t  alu_op;
        wb_sel_t  wb_sel;
        hilo_wr_t hilo_wr;
    } dec_ctrl_t;

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;

    // divider result layout, remainder on top
    typedef struct packed {
        mips_isa_pkg::word_t rem;
        mips_isa_pkg::word_t quot;
    } div_res_t;

    localparam int DIV_STEPS = $bits(mips_isa_pkg::word_t);  // one step per quotient bit
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);
    localparam int DIV_RES_W = $bits(mips_isa_pkg::dword_t);

    typedef logic [DIV_CNT_W-1:0] div_cnt_t;

endpackage

`default_nettype wire

// ==== logic/alu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
    input  mips_isa_pkg::word_t instr,
    input  mips_isa_pkg::word_t rs_val,
    input  mips_isa_pkg::word_t rt_val,
    output mips_isa_pkg::word_t src_a,
    output mips_isa_pkg::word_t src_b,
    output mips_isa_pkg::shamt_t sa,
    output alu_pkg::dec_ctrl_t ctrl
);

    mips_isa_pkg::opcode_t opcode;
    mips_isa_pkg::funct_t  funct;
    mips_isa_pkg::imm_t    imm;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    always_comb begin
        ctrl.alu_op  = alu_pkg::ALU_NONE;
        ctrl.wb_sel  = alu_pkg::WB_NONE;
        ctrl.hilo_wr = alu_pkg::HILO_NONE;
        src_a = rs_val;
        src_b = rt_val;
        sa    = '0;
        if (opcode == mips_isa_pkg::OP_RTYPE) begin
            ctrl.wb_sel = alu_pkg::WB_ALU;
            case (funct)
                mips_isa_pkg::FN_AND:  ctrl.alu_op = alu_pkg::ALU_AND;
                mips_isa_pkg::FN_OR:   ctrl.alu_op = alu_pkg::ALU_OR;
                mips_isa_pkg::FN_NOR:  ctrl.alu_op = alu_pkg::ALU_NOR;
                mips_isa_pkg::FN_XOR:  ctrl.alu_op = alu_pkg::ALU_XOR;
                mips_isa_pkg::FN_ADD:  ctrl.alu_op = alu_pkg::ALU_ADD;
                mips_isa_pkg::FN_ADDU: ctrl.alu_op = alu_pkg::ALU_ADDU;
                mips_isa_pkg::FN_SUB:  ctrl.alu_op = alu_pkg::ALU_SUB;
                mips_isa_pkg::FN_SUBU: ctrl.alu_op = alu_pkg::ALU_SUBU;
                mips_isa_pkg::FN_SLT:  ctrl.alu_op = alu_pkg::ALU_SLT;
                mips_isa_pkg::FN_SLTU: ctrl.alu_op = alu_pkg::ALU_SLTU;
                mips_isa_pkg::FN_SLLV: ctrl.alu_op = alu_pkg::ALU_SLL;  // amount from rs
                mips_isa_pkg::FN_SRLV: ctrl.alu_op = alu_pkg::ALU_SRL;
                mips_isa_pkg::FN_SRAV: ctrl.alu_op = alu_pkg::ALU_SRA;
                mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL, mips_isa_pkg::FN_SRA: begin
                    // fixed amount comes from the shamt field, rs plays no part
                    src_a = '0;
                    sa    = instr[10:6];
                    case (funct)
                        mips_isa_pkg::FN_SLL: ctrl.alu_op = alu_pkg::ALU_SLL;
                        mips_isa_pkg::FN_SRL: ctrl.alu_op = alu_pkg::ALU_SRL;
                        default:              ctrl.alu_op = alu_pkg::ALU_SRA;
                    endcase
                end
                mips_isa_pkg::FN_MULT, mips_isa_pkg::FN_MULTU: begin
                    ctrl.alu_op  = (funct == mips_isa_pkg::FN_MULT) ? alu_pkg::ALU_MULT
                                                                   : alu_pkg::ALU_MULTU;
                    ctrl.wb_sel  = alu_pkg::WB_NONE;
                    ctrl.hilo_wr = alu_pkg::HILO_PRODUCT;
                end
                mips_isa_pkg::FN_DIV, mips_isa_pkg::FN_DIVU: begin
                    ctrl.alu_op  = (funct == mips_isa_pkg::FN_DIV) ? alu_pkg::ALU_DIV
                                                                  : alu_pkg::ALU_DIVU;
                    ctrl.wb_sel  = alu_pkg::WB_NONE;
                    ctrl.hilo_wr = alu_pkg::HILO_DIVIDE;
                end
                mips_isa_pkg::FN_MFHI: ctrl.wb_sel = alu_pkg::WB_HI;
                mips_isa_pkg::FN_MFLO: ctrl.wb_sel = alu_pkg::WB_LO;
                mips_isa_pkg::FN_MTHI, mips_isa_pkg::FN_MTLO: begin
                    ctrl.alu_op  = alu_pkg::ALU_PASS_A;
                    ctrl.wb_sel  = alu_pkg::WB_NONE;
                    ctrl.hilo_wr = (funct == mips_isa_pkg::FN_MTHI) ? alu_pkg::HILO_HI
                                                                   : alu_pkg::HILO_LO;
                end
                default: ctrl.wb_sel = alu_pkg::WB_NONE;  // unknown funct
            endcase
        end else begin
            ctrl.wb_sel = alu_pkg::WB_ALU;
            src_b = {{16{imm[15]}}, imm};  // sign extended unless logical
            case (opcode)
                mips_isa_pkg::OP_ADDI:  ctrl.alu_op = alu_pkg::ALU_ADD;
                mips_isa_pkg::OP_ADDIU: ctrl.alu_op = alu_pkg::ALU_ADDU;
                mips_isa_pkg::OP_SLTI:  ctrl.alu_op = alu_pkg::ALU_SLT;
                mips_isa_pkg::OP_SLTIU: ctrl.alu_op = alu_pkg::ALU_SLTU;
                mips_isa_pkg::OP_LUI:   ctrl.alu_op = alu_pkg::ALU_LUI;
                mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI: begin
                    src_b = {16'b0, imm};
                    case (opcode)
                        mips_isa_pkg::OP_ANDI: ctrl.alu_op = alu_pkg::ALU_AND;
                        mips_isa_pkg::OP_ORI:  ctrl.alu_op = alu_pkg::ALU_OR;
                        default:               ctrl.alu_op = alu_pkg::ALU_XOR;
                    endcase
                end
                default: ctrl.wb_sel = alu_pkg::WB_NONE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/mul_booth2.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_booth2 (
    input  mips_isa_pkg::word_t a,
    input  mips_isa_pkg::word_t b,
    input  logic sign,          // 1 for signed operands
    output mips_isa_pkg::dword_t result
);

    logic [33:0] a_x;
    logic [33:0] b_x;
    logic [34:0] b_grp;          // b with the implicit zero below bit 0
    mips_isa_pkg::dword_t a_w;
    mips_isa_pkg::dword_t pp;
    mips_isa_pkg::dword_t acc;
    logic [2:0] grp;

    // two extra bits so an unsigned operand stays positive
    assign a_x   = {{2{sign & a[31]}}, a};
    assign b_x   = {{2{sign & b[31]}}, b};
    assign b_grp = {b_x, 1'b0};
    assign a_w   = {{30{a_x[33]}}, a_x};

    always_comb begin
        acc = '0;
        pp  = '0;
        grp = '0;
        for (int i = 0; i < $bits(mips_isa_pkg::word_t) / 2 + 1; i++) begin
            grp = b_grp[2*i +: 3];
            case (grp)
                3'b001, 3'b010: pp = a_w;
                3'b011:         pp = a_w << 1;
                3'b100:         pp = -(a_w << 1);
                3'b101, 3'b110: pp = -a_w;
                default:        pp = '0;   // 000 and 111
            endcase
            acc = acc + (pp << (2 * i));  // wraps mod 2^64, upper bits fall away
        end
    end

    assign result = acc;

endmodule

`default_nettype wire

// ==== logic/div_radix2.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_radix2 (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic sign,          // 1 for signed operands
    input  mips_isa_pkg::word_t a,
    input  mips_isa_pkg::word_t b,
    output logic busy,
    output mips_isa_pkg::dword_t result
);

    alu_pkg::div_state_t state_q;
    alu_pkg::div_cnt_t   cnt_q;
    mips_isa_pkg::word_t rem_q;
    mips_isa_pkg::word_t quot_q;    // holds the dividend at first, shifts out to quotient
    mips_isa_pkg::word_t dsor_q;
    logic neg_q_q;                  // quotient sign
    logic neg_r_q;                  // remainder sign
    mips_isa_pkg::word_t a_abs;
    mips_isa_pkg::word_t b_abs;
    logic [32:0] partial;
    logic [32:0] diff;
    logic last_step;
    alu_pkg::div_res_t res;

    assign a_abs = (sign && a[31]) ? -a : a;
    assign b_abs = (sign && b[31]) ? -b : b;

    // one restoring step
    assign partial = {rem_q, quot_q[31]};
    assign diff    = partial - {1'b0, dsor_q};

    assign last_step = (cnt_q == alu_pkg::div_cnt_t'(alu_pkg::DIV_STEPS - 1));
    assign busy = (state_q == alu_pkg::DIV_RUN) || (state_q == alu_pkg::DIV_IDLE && start);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= alu_pkg::DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                alu_pkg::DIV_IDLE: begin
                    cnt_q <= '0;
                    if (start)
                        state_q <= alu_pkg::DIV_RUN;
                end
                alu_pkg::DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step)
                        state_q <= alu_pkg::DIV_DONE;
                end
                default: state_q <= alu_pkg::DIV_IDLE;  // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == alu_pkg::DIV_IDLE && start) begin
            rem_q   <= '0;
            quot_q  <= a_abs;
            dsor_q  <= b_abs;
            neg_q_q <= sign & (a[31] ^ b[31]);
            neg_r_q <= sign & a[31];
        end else if (state_q == alu_pkg::DIV_RUN) begin
            if (!diff[32]) begin
                rem_q  <= diff[31:0];
                quot_q <= {quot_q[30:0], 1'b1};
            end else begin
                rem_q  <= partial[31:0];
                quot_q <= {quot_q[30:0], 1'b0};  // restore
            end
        end
    end

    // divide by zero never borrows: quotient all ones, remainder the dividend
    assign res.rem  = neg_r_q ? -rem_q : rem_q;
    assign res.quot = neg_q_q ? -quot_q : quot_q;
    assign result   = alu_pkg::DIV_RES_W'(res);

    // source has to hold the divide until the result is taken
    a_start_held: assert property (
        @(posedge clk) disable iff (!rst_n) (state_q == alu_pkg::DIV_RUN) |-> start
    );

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_valid,
    input  mips_isa_pkg::word_t src_a,
    input  mips_isa_pkg::word_t src_b,
    input  mips_isa_pkg::shamt_t sa,
    input  alu_pkg::alu_op_t op,
    output mips_isa_pkg::word_t alu_out,
    output mips_isa_pkg::dword_t wide_out,
    output logic overflow,
    output logic div_busy
);

    mips_isa_pkg::word_t  res;
    mips_isa_pkg::shamt_t shamt;
    mips_isa_pkg::dword_t mul_res;
    mips_isa_pkg::dword_t div_res;
    logic carry;   // extra sign bit of the 33-bit add/sub
    logic is_add_sub;
    logic mul_sign;
    logic div_sign;
    logic is_div;

    // decode zeroes whichever of the two amounts does not apply
    assign shamt = src_a[4:0] | sa;

    always_comb begin
        carry = 1'b0;
        case (op)
            alu_pkg::ALU_AND:    res = src_a & src_b;
            alu_pkg::ALU_OR:     res = src_a | src_b;
            alu_pkg::ALU_NOR:    res = ~(src_a | src_b);
            alu_pkg::ALU_XOR:    res = src_a ^ src_b;
            alu_pkg::ALU_ADD:    {carry, res} = {src_a[31], src_a} + {src_b[31], src_b};
            alu_pkg::ALU_ADDU:   res = src_a + src_b;
            alu_pkg::ALU_SUB:    {carry, res} = {src_a[31], src_a} - {src_b[31], src_b};
            alu_pkg::ALU_SUBU:   res = src_a - src_b;
            alu_pkg::ALU_SLT:    res = mips_isa_pkg::word_t'($signed(src_a) < $signed(src_b));
            alu_pkg::ALU_SLTU:   res = mips_isa_pkg::word_t'(src_a < src_b);
            alu_pkg::ALU_SLL:    res = src_b << shamt;
            alu_pkg::ALU_SRL:    res = src_b >> shamt;
            alu_pkg::ALU_SRA:    res = $signed(src_b) >>> shamt;
            alu_pkg::ALU_LUI:    res = {src_b[15:0], 16'b0};
            alu_pkg::ALU_PASS_A: res = src_a;
            default:             res = '0;  // mul/div go out on wide_out
        endcase
    end

    assign alu_out    = res;
    assign is_add_sub = (op == alu_pkg::ALU_ADD) || (op == alu_pkg::ALU_SUB);
    assign overflow   = instr_valid & is_add_sub & (carry ^ res[31]);

    assign mul_sign = (op == alu_pkg::ALU_MULT);
    assign div_sign = (op == alu_pkg::ALU_DIV);
    assign is_div   = div_sign || (op == alu_pkg::ALU_DIVU);

    mul_booth2 u_mul (
        .a      (src_a),
        .b      (src_b),
        .sign   (mul_sign),
        .result (mul_res)
    );

    div_radix2 u_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (instr_valid & is_div),
        .sign   (div_sign),
        .a      (src_a),   // dividend
        .b      (src_b),   // divisor
        .busy   (div_busy),
        .result (div_res)
    );

    assign wide_out = is_div ? div_res : mul_res;

    // signed add/sub only, operand signs must allow it and the result sign flips
    a_ovf_sign_rule: assert property (
        @(posedge clk) disable iff (!rst_n)
        overflow |-> is_add_sub && (res[31] != src_a[31])
                     && ((src_a[31] ^ src_b[31]) == (op == alu_pkg::ALU_SUB))
    );

endmodule

`default_nettype wire

// ==== logic/exec_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_result (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_valid,
    input  logic stall,
    input  alu_pkg::dec_ctrl_t ctrl,
    input  mips_isa_pkg::word_t src_a,
    input  mips_isa_pkg::word_t alu_out,
    input  mips_isa_pkg::dword_t wide_out,
    output mips_isa_pkg::word_t wb_data
);

    mips_isa_pkg::word_t hi_q;
    mips_isa_pkg::word_t lo_q;
    logic wr_en;

    assign wr_en = instr_valid & ~stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (wr_en) begin
            case (ctrl.hilo_wr)
                // product and {rem, quot} share the same layout
                alu_pkg::HILO_PRODUCT, alu_pkg::HILO_DIVIDE: {hi_q, lo_q} <= wide_out;
                alu_pkg::HILO_HI: hi_q <= src_a;
                alu_pkg::HILO_LO: lo_q <= src_a;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            alu_pkg::WB_ALU: wb_data = alu_out;
            alu_pkg::WB_HI:  wb_data = hi_q;
            alu_pkg::WB_LO:  wb_data = lo_q;
            default:         wb_data = '0;
        endcase
    end

    // divide result only taken right after the divider has run
    a_div_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en && ctrl.hilo_wr == alu_pkg::HILO_DIVIDE) |-> $past(stall)
    );

endmodule

`default_nettype wire

// ==== logic/exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_valid,
    input  mips_isa_pkg::word_t instr,
    input  mips_isa_pkg::word_t rs_val,
    input  mips_isa_pkg::word_t rt_val,
    output mips_isa_pkg::word_t wb_data,
    output logic overflow,
    output logic stall
);

    mips_isa_pkg::word_t  src_a;
    mips_isa_pkg::word_t  src_b;
    mips_isa_pkg::shamt_t sa;
    alu_pkg::dec_ctrl_t   ctrl;
    mips_isa_pkg::word_t  alu_out;
    mips_isa_pkg::dword_t wide_out;

    alu_decode u_decode (
        .instr  (instr),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .src_a  (src_a),
        .src_b  (src_b),
        .sa     (sa),
        .ctrl   (ctrl)
    );

    alu u_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .src_a       (src_a),
        .src_b       (src_b),
        .sa          (sa),
        .op          (ctrl.alu_op),
        .alu_out     (alu_out),
        .wide_out    (wide_out),
        .overflow    (overflow),
        .div_busy    (stall)      // divider busy is the pipeline stall
    );

    exec_result u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .stall       (stall),
        .ctrl        (ctrl),
        .src_a       (src_a),
        .alu_out     (alu_out),
        .wide_out    (wide_out),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top;

    localparam int N_RAND     = 8;                // random rounds per test
    // operations issued by all tests together
    localparam int N_OPS      = 2 + N_RAND * 24 + 30 + (N_RAND + 4) * 3 + 4
                                + (N_RAND + 7) * 3;
    localparam int CYCLE_LIM  = N_OPS * 40 + 200;
    localparam int DIV_CYCLES = 33;               // load cycle plus 32 steps

    logic clk;
    logic rst_n;
    logic instr_valid;
    mips_isa_pkg::word_t instr;
    mips_isa_pkg::word_t rs_val;
    mips_isa_pkg::word_t rt_val;
    mips_isa_pkg::word_t wb_data;
    logic overflow;
    logic stall;

    logic [31:0] lfsr_q;
    int cycle_cnt = 0;

    exec_top u_exec_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .wb_data     (wb_data),
        .overflow    (overflow),
        .stall       (stall)
    );

    always #5 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIM) begin
            $display("the run did not finish within %0d cycles", CYCLE_LIM);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_word(output mips_isa_pkg::word_t w);
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[i] = lfsr_q[0];
        end
    endtask

    function automatic mips_isa_pkg::word_t r_instr(input mips_isa_pkg::funct_t fn,
                                                    input mips_isa_pkg::shamt_t sh);
        return {mips_isa_pkg::OP_RTYPE, 5'd1, 5'd2, 5'd3, sh, fn};
    endfunction

    function automatic mips_isa_pkg::word_t i_instr(input mips_isa_pkg::opcode_t op,
                                                    input mips_isa_pkg::imm_t imm);
        return {op, 5'd1, 5'd2, imm};
    endfunction

    // signed result outside 32 bits
    function automatic logic add_ovf(input mips_isa_pkg::word_t a,
                                     input mips_isa_pkg::word_t b, input logic subtract);
        longint r;
        if (subtract)
            r = longint'($signed(a)) - longint'($signed(b));
        else
            r = longint'($signed(a)) + longint'($signed(b));
        return longint'($signed(r[31:0])) != r;
    endfunction

    task automatic check_val(input string name, input mips_isa_pkg::word_t got,
                             input mips_isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic issue(input mips_isa_pkg::word_t ins, input mips_isa_pkg::word_t a,
                         input mips_isa_pkg::word_t b);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = ins;
        rs_val      = a;
        rt_val      = b;
        #1;  // let the combinational path settle
    endtask

    task automatic simple_op(input mips_isa_pkg::word_t ins, input mips_isa_pkg::word_t a,
                             input mips_isa_pkg::word_t b, input mips_isa_pkg::word_t exp_wb,
                             input logic exp_ovf);
        issue(ins, a, b);
        check_val("wb_data", wb_data, exp_wb);
        check_val("overflow", 32'(overflow), 32'(exp_ovf));
        check_val("stall", 32'(stall), 32'd0);
    endtask

    task automatic after_reset();
        @(negedge clk);
        instr = r_instr(mips_isa_pkg::FN_ADD, 5'd0);
        rs_val = 32'h7fffffff;
        rt_val = 32'h00000001;
        #1;
        check_val("overflow", 32'(overflow), 32'd0);  // valid still low
        check_val("stall", 32'(stall), 32'd0);
        simple_op(r_instr(mips_isa_pkg::FN_MFHI, 5'd0), '0, '0, '0, 1'b0);
        simple_op(r_instr(mips_isa_pkg::FN_MFLO, 5'd0), '0, '0, '0, 1'b0);
    endtask

    task automatic alu_ops();
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        mips_isa_pkg::word_t sx;
        mips_isa_pkg::word_t zx;
        mips_isa_pkg::imm_t  imm;
        for (int n = 0; n < N_RAND; n++) begin
            rand_word(a);
            rand_word(b);
            imm = b[15:0];
            sx  = {{16{imm[15]}}, imm};
            zx  = {16'h0, imm};
            simple_op(r_instr(mips_isa_pkg::FN_AND, 5'd0), a, b, a & b, 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_OR, 5'd0), a, b, a | b, 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_NOR, 5'd0), a, b, ~(a | b), 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_XOR, 5'd0), a, b, a ^ b, 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_ADD, 5'd0), a, b, a + b, add_ovf(a, b, 1'b0));
            simple_op(r_instr(mips_isa_pkg::FN_ADDU, 5'd0), a, b, a + b, 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_SUB, 5'd0), a, b, a - b, add_ovf(a, b, 1'b1));
            simple_op(r_instr(mips_isa_pkg::FN_SUBU, 5'd0), a, b, a - b, 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_SLT, 5'd0), a, b,
                      32'($signed(a) < $signed(b)), 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_SLTU, 5'd0), a, b, 32'(a < b), 1'b0);
            // immediate forms ignore rt
            simple_op(i_instr(mips_isa_pkg::OP_ANDI, imm), a, b, a & zx, 1'b0);
            simple_op(i_instr(mips_isa_pkg::OP_ORI, imm), a, b, a | zx, 1'b0);
            simple_op(i_instr(mips_isa_pkg::OP_XORI, imm), a, b, a ^ zx, 1'b0);
            simple_op(i_instr(mips_isa_pkg::OP_ADDI, imm), a, b, a + sx, add_ovf(a, sx, 1'b0));
            simple_op(i_instr(mips_isa_pkg::OP_ADDIU, imm), a, b, a + sx, 1'b0);
            simple_op(i_instr(mips_isa_pkg::OP_SLTI, imm), a, b,
                      32'($signed(a) < $signed(sx)), 1'b0);
            simple_op(i_instr(mips_isa_pkg::OP_SLTIU, imm), a, b, 32'(a < sx), 1'b0);
            simple_op(i_instr(mips_isa_pkg::OP_LUI, imm), a, b, {imm, 16'h0}, 1'b0);
        end
    endtask

    task automatic shifts();
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        mips_isa_pkg::word_t c;
        mips_isa_pkg::shamt_t sh;
        for (int n = 0; n < N_RAND; n++) begin
            rand_word(a);
            rand_word(b);
            rand_word(c);
            sh = c[4:0];
            simple_op(r_instr(mips_isa_pkg::FN_SLL, sh), a, b, b << sh, 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_SRL, sh), a, b, b >> sh, 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_SRA, sh), a, b, 32'($signed(b) >>> sh), 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_SLLV, 5'd0), a, b, b << a[4:0], 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_SRLV, 5'd0), a, b, b >> a[4:0], 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_SRAV, 5'd0), a, b,
                      32'($signed(b) >>> a[4:0]), 1'b0);
        end
    endtask

    task automatic overflow_flag();
        mips_isa_pkg::word_t pairs [10];
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        mips_isa_pkg::word_t sx;
        pairs = '{32'h7fffffff, 32'h00000001, 32'h80000000, 32'h00000001,
                  32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000,
                  32'h40000000, 32'h40000000};
        for (int i = 0; i < 5; i++) begin
            a  = pairs[2*i];
            b  = pairs[2*i+1];
            sx = {{16{b[15]}}, b[15:0]};
            simple_op(r_instr(mips_isa_pkg::FN_ADD, 5'd0), a, b, a + b, add_ovf(a, b, 1'b0));
            simple_op(r_instr(mips_isa_pkg::FN_ADDU, 5'd0), a, b, a + b, 1'b0);
            simple_op(r_instr(mips_isa_pkg::FN_SUB, 5'd0), a, b, a - b, add_ovf(a, b, 1'b1));
            simple_op(r_instr(mips_isa_pkg::FN_SUBU, 5'd0), a, b, a - b, 1'b0);
            simple_op(i_instr(mips_isa_pkg::OP_ADDI, b[15:0]), a, b, a + sx,
                      add_ovf(a, sx, 1'b0));
            simple_op(i_instr(mips_isa_pkg::OP_ADDIU, b[15:0]), a, b, a + sx, 1'b0);
        end
    endtask

    task automatic read_hilo(input mips_isa_pkg::word_t exp_hi, input mips_isa_pkg::word_t exp_lo);
        simple_op(r_instr(mips_isa_pkg::FN_MFHI, 5'd0), '0, '0, exp_hi, 1'b0);
        simple_op(r_instr(mips_isa_pkg::FN_MFLO, 5'd0), '0, '0, exp_lo, 1'b0);
    endtask

    task automatic mult_and_read(input mips_isa_pkg::word_t a, input mips_isa_pkg::word_t b,
                                 input logic signed_op);
        mips_isa_pkg::dword_t p;
        p = {{32{signed_op & a[31]}}, a} * {{32{signed_op & b[31]}}, b};  // exact mod 2^64
        simple_op(r_instr(signed_op ? mips_isa_pkg::FN_MULT : mips_isa_pkg::FN_MULTU, 5'd0),
                  a, b, '0, 1'b0);
        read_hilo(p[63:32], p[31:0]);
    endtask

    task automatic multiplies();
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        for (int n = 0; n < N_RAND; n++) begin
            rand_word(a);
            rand_word(b);
            mult_and_read(a, b, n[0]);
        end
        mult_and_read(32'h80000000, 32'h80000000, 1'b1);
        mult_and_read(32'hffffffff, 32'hffffffff, 1'b0);
        mult_and_read(32'hffffffff, 32'h00000001, 1'b1);
        mult_and_read(32'h7fffffff, 32'h80000000, 1'b1);
    endtask

    task automatic hilo_moves();
        mips_isa_pkg::word_t h;
        mips_isa_pkg::word_t l;
        rand_word(h);
        rand_word(l);
        simple_op(r_instr(mips_isa_pkg::FN_MTHI, 5'd0), h, '0, '0, 1'b0);
        simple_op(r_instr(mips_isa_pkg::FN_MTLO, 5'd0), l, '0, '0, 1'b0);
        read_hilo(h, l);
    endtask

    task automatic div_and_read(input mips_isa_pkg::word_t a, input mips_isa_pkg::word_t b,
                                input logic signed_op);
        mips_isa_pkg::word_t q;
        mips_isa_pkg::word_t r;
        mips_isa_pkg::word_t a_mag;
        mips_isa_pkg::word_t b_mag;
        int stall_cycles;
        a_mag = (signed_op && a[31]) ? -a : a;
        b_mag = (signed_op && b[31]) ? -b : b;
        if (b_mag == '0) begin
            q = '1;  // unsigned divide by zero
            r = a;
        end else begin
            q = a_mag / b_mag;
            r = a_mag % b_mag;
            if (signed_op && (a[31] ^ b[31]))
                q = -q;
            if (signed_op && a[31])
                r = -r;
        end
        issue(r_instr(signed_op ? mips_isa_pkg::FN_DIV : mips_isa_pkg::FN_DIVU, 5'd0), a, b);
        stall_cycles = 0;
        while (stall) begin  // operands stay held while stalled
            stall_cycles++;
            @(negedge clk);
            #1;
        end
        check_val("stall cycles", 32'(stall_cycles), 32'(DIV_CYCLES));
        read_hilo(r, q);
    endtask

    task automatic divides();
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        for (int n = 0; n < N_RAND; n++) begin
            rand_word(a);
            rand_word(b);
            if (n[1])
                b = b >> n;  // small divisors too
            if (b == '0)
                b = 32'd1;
            div_and_read(a, b, n[0]);
        end
        div_and_read(-32'd100, 32'd7, 1'b1);
        div_and_read(32'd100, -32'd7, 1'b1);
        div_and_read(-32'd100, -32'd7, 1'b1);
        div_and_read(32'h80000000, 32'd3, 1'b1);
        div_and_read(32'hffffffff, 32'h00000010, 1'b0);
        div_and_read(32'h12345678, 32'h0, 1'b0);
        div_and_read(32'hffffffff, 32'h0, 1'b0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rs_val      = '0;
        rt_val      = '0;
        lfsr_q      = 32'd75;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        after_reset();
        alu_ops();
        shifts();
        overflow_flag();
        multiplies();
        hilo_moves();
        divides();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/mips_isa_pkg.sv
logic/alu_pkg.sv
logic/alu_decode.sv
logic/mul_booth2.sv
logic/div_radix2.sv
logic/alu.sv
logic/exec_result.sv
logic/exec_top.sv
tb/tb_exec_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
